// File: rv_pipeline.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/rv_decoder.sv
hdl/hazard_unit.sv
hdl/rv_pipeline.sv
verification/rv_pipeline_chk.sv
verification/rv_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_pipeline_tb
FILELIST  ?= rv_pipeline.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/rv_pipeline_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline_tb import rv_pkg::*;;

  localparam int unsigned TIMEOUT  = 3000;
  localparam logic [31:0] SEED     = 32'd38;
  localparam word_t       POISON   = 32'hdead_0000;
  localparam logic [6:0]  OPC_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD = 7'b0000011;
  localparam logic [6:0]  F7_ALT   = 7'b0100000;

  logic      clk = 1'b0;
  logic      nrst;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  logic      dmem_ready = 1'b0;
  word_t     dmem_rdata = '0;
  logic      halt;

  word_t       rom [64];
  int unsigned prog_len = 0;
  word_t       dmem [256];
  logic [31:0] lcg_state = 32'd0;
  logic [63:0] exp_stores [$];
  int unsigned store_errors = 0;
  int unsigned end_errors = 0;

  always #10 clk = ~clk;

  rv_pipeline #(.PC_INIT(32'h0)) uut (
    .clk        (clk),
    .nrst       (nrst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  bind rv_pipeline rv_pipeline_chk chk (
    .clk        (clk),
    .nrst       (nrst),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready),
    .halt       (halt)
  );

  // Past the program the ROM returns NOPs
  assign imem_data = (32'(imem_addr[31:2]) < prog_len) ? rom[imem_addr[7:2]] : NOP_INST;

  function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_addr_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                   input reg_addr_t rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input reg_addr_t rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                   input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h0100_0193) ^ 32'h811c_9dc5;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic emit(input word_t inst);
    rom[prog_len[5:0]] = inst;
    prog_len++;
  endtask

  // sw rs2 to x1 plus offset where x1 holds 0x100
  task automatic store_reg(input reg_addr_t rs2, input logic [11:0] off, input word_t value);
    emit(s_type(rs2, 5'd1, off));
    exp_stores.push_back({32'h100 + {20'b0, off}, value});
  endtask

  // Slots that a taken branch must squash
  task automatic poison_slots();
    repeat (3) emit(s_type(5'd19, 5'd1, 12'd64));
  endtask

  task automatic load_program();
    word_t link;
    emit(i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'h100));
    emit(i_type(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'd5));
    emit(i_type(OPC_IMM, 3'b000, 5'd3, 5'd2, 12'd7));
    emit(r_type(7'd0, 3'b000, 5'd4, 5'd3, 5'd2));
    emit(r_type(F7_ALT, 3'b000, 5'd5, 5'd4, 5'd3));
    emit(r_type(7'd0, 3'b001, 5'd6, 5'd4, 5'd5));
    emit(r_type(7'd0, 3'b100, 5'd7, 5'd6, 5'd4));
    emit(u_type(5'd8, 20'h80000));
    emit(r_type(F7_ALT, 3'b101, 5'd9, 5'd8, 5'd5));
    emit(r_type(7'd0, 3'b011, 5'd10, 5'd5, 5'd8));
    emit(r_type(7'd0, 3'b010, 5'd11, 5'd5, 5'd8));
    emit(r_type(7'd0, 3'b101, 5'd12, 5'd8, 5'd5));
    emit(r_type(7'd0, 3'b111, 5'd13, 5'd7, 5'd4));
    emit(r_type(7'd0, 3'b110, 5'd14, 5'd13, 5'd9));
    // srai by 4, then minus one
    emit(i_type(OPC_IMM, 3'b101, 5'd15, 5'd9, 12'h404));
    emit(i_type(OPC_IMM, 3'b000, 5'd16, 5'd15, 12'hfff));
    store_reg(5'd16, 12'd0, 32'hffc0_0000 - 32'd1);
    store_reg(5'd4, 12'd4, 32'd12 + 32'd5);
    store_reg(5'd6, 12'd8, 32'd17 << 5);
    store_reg(5'd7, 12'd12, (32'd17 << 5) ^ 32'd17);
    store_reg(5'd9, 12'd16, 32'hfc00_0000);
    store_reg(5'd10, 12'd20, 32'd1);
    store_reg(5'd11, 12'd24, 32'd0);
    store_reg(5'd12, 12'd28, 32'h8000_0000 >> 5);
    store_reg(5'd14, 12'd32, 32'hfc00_0000 | (((32'd17 << 5) ^ 32'd17) & 32'd17));
    // Load-use pair reading 0x80
    emit(i_type(OPC_LOAD, 3'b010, 5'd17, 5'd1, 12'hf80));
    emit(r_type(7'd0, 3'b000, 5'd18, 5'd17, 5'd2));
    store_reg(5'd18, 12'd36, fill_word(32'h80) + 32'd5);
    emit(u_type(5'd19, POISON[31:12]));
    emit(i_type(OPC_IMM, 3'b000, 5'd21, 5'd0, 12'd5));
    emit(b_type(3'b000, 5'd21, 5'd2, 13'd16));
    poison_slots();
    store_reg(5'd3, 12'd40, 32'd12);
    emit(b_type(3'b001, 5'd4, 5'd3, 13'd16));
    poison_slots();
    store_reg(5'd5, 12'd44, 32'd5);
    link = {prog_len[29:0], 2'b00} + 32'd4;
    emit(j_type(5'd20, 21'd16));
    poison_slots();
    store_reg(5'd20, 12'd48, link);
    emit(HALT_INST);
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    logic [63:0] exp;
    assert (data != POISON) else begin
      $display("** Error at %0t: squashed store wrote %h to %h", $time, data, addr);
      store_errors++;
    end
    assert (exp_stores.size() > 0) else begin
      $display("** Error at %0t: store of %h to %h with none expected", $time, data, addr);
      store_errors++;
    end
    if (exp_stores.size() > 0) begin
      exp = exp_stores.pop_front();
      assert ({addr, data} == exp) else begin
        $display("** Error at %0t: store %h to %h, expected %h to %h",
                 $time, data, addr, exp[31:0], exp[63:32]);
        store_errors++;
      end
    end
    dmem[addr[9:2]] = data;
  endtask

  // Data memory model decides the handshake for the coming rising edge
  always @(negedge clk) begin
    if (!nrst) begin
      lcg_state = SEED;
      dmem_ready = 1'b0;
      for (int i = 0; i < 256; i++) begin
        dmem[i[7:0]] = fill_word(32'(i) << 2);
      end
    end else begin
      lcg_state = lcg_next(lcg_state);
      dmem_ready = (lcg_state[23:16] % 8'd3) != 8'd0;
      if (dmem_req.valid) begin
        dmem_rdata = dmem[dmem_req.addr[9:2]];
        if (dmem_ready && dmem_req.write) begin
          check_store(dmem_req.addr, dmem_req.wdata);
        end
      end
    end
  end

  initial begin
    int unsigned cycles;
    nrst = 1'b0;
    load_program();
    repeat (8) @(negedge clk);
    nrst <= 1'b1;
    cycles = 0;
    while (!halt && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("Timeout: halt never arrived within %0d cycles", TIMEOUT);
      end_errors++;
    end else begin
      assert (exp_stores.size() == 0) else begin
        $display("Halt seen with %0d expected stores missing", exp_stores.size());
        end_errors++;
      end
    end
    // Let the halt assertions see a few more edges
    repeat (4) @(negedge clk);
    $display("Errors: %0d store, %0d assertion, %0d end of run",
             store_errors, uut.chk.fail_count, end_errors);
    if (store_errors + end_errors + uut.chk.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/rv_pipeline_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline_chk import rv_pkg::*; (
  input logic      clk,
  input logic      nrst,
  input dmem_req_t dmem_req,
  input logic      dmem_ready,
  input logic      halt
);

  int unsigned fail_count = 0;

  // Outputs quiet while in reset
  reset_quiet: assert property (@(posedge clk) !nrst |-> !dmem_req.valid && !halt)
    else begin
      $error("data request or halt active during reset");
      fail_count++;
    end

  // A waiting request must not change
  req_held: assert property (@(posedge clk) disable iff (!nrst)
    dmem_req.valid && !dmem_ready |=> $stable(dmem_req))
    else begin
      $error("data request changed while ready was low");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!nrst) halt |=> halt)
    else begin
      $error("halt dropped without reset");
      fail_count++;
    end

  // Pipeline drained two cycles after halt
  quiet_after_halt: assert property (@(posedge clk) disable iff (!nrst)
    $past(halt, 2) |-> !dmem_req.valid)
    else begin
      $error("data request valid after halt");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: hdl/rv_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline import rv_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic      clk,
  input  logic      nrst,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  logic      dmem_ready,
  input  word_t     dmem_rdata,
  output logic      halt
);

  localparam f2d_t F2D_BUBBLE = '{pc: '0, inst: NOP_INST};

  word_t pc;
  word_t pc_n;

  f2d_t f2d_q;
  d2e_t d2e_q;
  e2m_t e2m_q;
  m2w_t m2w_q;

  stage_ctrl_t stage;
  fwd_sel_t    fwd_a;
  fwd_sel_t    fwd_b;

  ctrl_t     dec_ctrl;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  word_t     rf_rdat1;
  word_t     rf_rdat2;

  word_t opa;
  word_t opb;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  logic  alu_zero;
  word_t mem_fwd;
  word_t wb_data;

  logic  branch_taken;
  word_t jump_target;
  logic  dmem_stall;

  rv_decoder dec0 (
    .inst (f2d_q.inst),
    .ctrl (dec_ctrl),
    .rs1  (dec_rs1),
    .rs2  (dec_rs2),
    .rd   (dec_rd),
    .imm  (dec_imm)
  );

  register_file rf0 (
    .clk   (clk),
    .nrst  (nrst),
    .rsel1 (dec_rs1),
    .rsel2 (dec_rs2),
    .rdat1 (rf_rdat1),
    .rdat2 (rf_rdat2),
    .wen   (m2w_q.ctrl.reg_write),
    .wsel  (m2w_q.rd),
    .wdat  (wb_data)
  );

  alu alu0 (
    .op     (d2e_q.ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // Sticky halt keeps fetch frozen after the halt leaves writeback
  hazard_unit haz0 (
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .ex_rs1        (d2e_q.rs1),
    .ex_rs2        (d2e_q.rs2),
    .ex_rd         (d2e_q.rd),
    .ex_mem_read   (d2e_q.ctrl.mem_read),
    .mem_rd        (e2m_q.rd),
    .mem_reg_write (e2m_q.ctrl.reg_write),
    .wb_rd         (m2w_q.rd),
    .wb_reg_write  (m2w_q.ctrl.reg_write),
    .branch_taken  (branch_taken),
    .dmem_stall    (dmem_stall),
    .wb_halt       (m2w_q.ctrl.halt | halt),
    .stage         (stage),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  // Fetch
  assign imem_addr = pc;
  assign pc_n      = branch_taken ? jump_target : pc + 32'd4;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      pc <= PC_INIT;
    end else if (stage.en_f2d) begin
      pc <= pc_n;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      f2d_q <= F2D_BUBBLE;
    end else if (stage.en_f2d) begin
      f2d_q <= stage.flush_f2d ? F2D_BUBBLE : '{pc: pc, inst: imem_data};
    end
  end

  // Decode into execute
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      d2e_q <= '0;
    end else if (stage.en_d2e) begin
      if (stage.flush_d2e) begin
        d2e_q <= '0;
      end else begin
        d2e_q <= '{pc: f2d_q.pc, ctrl: dec_ctrl, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                   imm: dec_imm, rdat1: rf_rdat1, rdat2: rf_rdat2};
      end
    end
  end

  // Execute operands
  assign mem_fwd = (e2m_q.ctrl.wb_src == WB_PC4) ? e2m_q.pc + 32'd4 : e2m_q.alu_out;

  always_comb begin
    case (fwd_a)
      FWD_MEM: opa = mem_fwd;
      FWD_WB:  opa = wb_data;
      default: opa = d2e_q.rdat1;
    endcase
    case (fwd_b)
      FWD_MEM: opb = mem_fwd;
      FWD_WB:  opb = wb_data;
      default: opb = d2e_q.rdat2;
    endcase
  end

  assign alu_a = d2e_q.ctrl.alu_src_pc ? d2e_q.pc : opa;
  assign alu_b = d2e_q.ctrl.alu_src_imm ? d2e_q.imm : opb;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      e2m_q <= '0;
    end else if (stage.en_e2m) begin
      if (stage.flush_e2m) begin
        e2m_q <= '0;
      end else begin
        e2m_q <= '{pc: d2e_q.pc, ctrl: d2e_q.ctrl, rd: d2e_q.rd, alu_out: alu_result,
                   alu_zero: alu_zero, br_target: d2e_q.pc + d2e_q.imm, store_data: opb};
      end
    end
  end

  // Memory stage, data port and branch resolution
  assign dmem_req.valid = e2m_q.ctrl.mem_read | e2m_q.ctrl.mem_write;
  assign dmem_req.write = e2m_q.ctrl.mem_write;
  assign dmem_req.addr  = e2m_q.alu_out;
  assign dmem_req.wdata = e2m_q.store_data;
  assign dmem_stall     = dmem_req.valid & ~dmem_ready;

  always_comb begin
    case (e2m_q.ctrl.pc_ctrl)
      PC_BEQ:  branch_taken = e2m_q.alu_zero;
      PC_BNE:  branch_taken = ~e2m_q.alu_zero;
      PC_JAL:  branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

  // JAL adds pc and offset in the ALU
  assign jump_target = (e2m_q.ctrl.pc_ctrl == PC_JAL) ? e2m_q.alu_out : e2m_q.br_target;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      m2w_q <= '0;
    end else if (stage.en_m2w) begin
      if (stage.flush_m2w) begin
        m2w_q <= '0;
      end else begin
        m2w_q <= '{pc: e2m_q.pc, ctrl: e2m_q.ctrl, rd: e2m_q.rd, alu_out: e2m_q.alu_out,
                   dload: dmem_rdata};
      end
    end
  end

  // Writeback
  always_comb begin
    case (m2w_q.ctrl.wb_src)
      WB_MEM:  wb_data = m2w_q.dload;
      WB_PC4:  wb_data = m2w_q.pc + 32'd4;
      default: wb_data = m2w_q.alu_out;
    endcase
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      halt <= 1'b0;
    end else begin
      halt <= halt | m2w_q.ctrl.halt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import rv_pkg::*; (
  input  reg_addr_t   dec_rs1,
  input  reg_addr_t   dec_rs2,
  input  reg_addr_t   ex_rs1,
  input  reg_addr_t   ex_rs2,
  input  reg_addr_t   ex_rd,
  input  logic        ex_mem_read,
  input  reg_addr_t   mem_rd,
  input  logic        mem_reg_write,
  input  reg_addr_t   wb_rd,
  input  logic        wb_reg_write,
  input  logic        branch_taken,
  input  logic        dmem_stall,
  input  logic        wb_halt,
  output stage_ctrl_t stage,
  output fwd_sel_t    fwd_a,
  output fwd_sel_t    fwd_b
);

  logic load_use;

  // Newest producer wins
  function automatic fwd_sel_t fwd_for(input reg_addr_t rs);
    if (rs != '0 && mem_reg_write && mem_rd == rs) begin
      fwd_for = FWD_MEM;
    end else if (rs != '0 && wb_reg_write && wb_rd == rs) begin
      fwd_for = FWD_WB;
    end else begin
      fwd_for = FWD_RF;
    end
  endfunction

  assign fwd_a = fwd_for(ex_rs1);
  assign fwd_b = fwd_for(ex_rs2);

  assign load_use = ex_mem_read && ex_rd != '0 &&
                    (ex_rd == dec_rs1 || ex_rd == dec_rs2);

  always_comb begin
    stage = '{en_f2d: 1'b1, en_d2e: 1'b1, en_e2m: 1'b1, en_m2w: 1'b1, default: 1'b0};
    if (dmem_stall) begin
      // Whole pipe waits for the data port
      stage.en_f2d = 1'b0;
      stage.en_d2e = 1'b0;
      stage.en_e2m = 1'b0;
      stage.en_m2w = 1'b0;
    end else if (branch_taken) begin
      stage.flush_f2d = 1'b1;
      stage.flush_d2e = 1'b1;
      stage.flush_e2m = 1'b1;
    end else if (wb_halt || load_use) begin
      // Hold fetch, feed bubbles into execute
      stage.en_f2d    = 1'b0;
      stage.flush_d2e = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t     inst,
  output ctrl_t     ctrl,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       use_rs1;
  logic       use_rs2;

  // alt selects sub/sra over add/srl
  function automatic alu_op_t funct_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  funct_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  always_comb begin
    ctrl    = '0;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    if (inst == HALT_INST) begin
      ctrl.halt = 1'b1;
    end else begin
      case (opcode)
        OPC_OP: begin
          ctrl.alu_op    = funct_op(funct3, inst[30]);
          ctrl.reg_write = 1'b1;
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
        end
        OPC_OP_IMM: begin
          // No subtract among immediates, bit 30 only picks srai
          ctrl.alu_op      = funct_op(funct3, inst[30] && funct3 == 3'b101);
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
          use_rs1          = 1'b1;
          imm              = {{20{inst[31]}}, inst[31:20]};
        end
        OPC_LUI: begin
          ctrl.alu_op      = ALU_PASS_B;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
          imm              = {inst[31:12], 12'b0};
        end
        OPC_LOAD: begin
          if (funct3 == 3'b010) begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.wb_src      = WB_MEM;
            use_rs1          = 1'b1;
            imm              = {{20{inst[31]}}, inst[31:20]};
          end
        end
        OPC_STORE: begin
          if (funct3 == 3'b010) begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
            use_rs1          = 1'b1;
            use_rs2          = 1'b1;
            imm              = {{20{inst[31]}}, inst[31:25], inst[11:7]};
          end
        end
        OPC_BRANCH: begin
          if (funct3 == 3'b000 || funct3 == 3'b001) begin
            // Compare by subtraction, zero flag decides
            ctrl.alu_op  = ALU_SUB;
            ctrl.pc_ctrl = (funct3 == 3'b000) ? PC_BEQ : PC_BNE;
            use_rs1      = 1'b1;
            use_rs2      = 1'b1;
            imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        OPC_JAL: begin
          ctrl.alu_src_pc  = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
          ctrl.wb_src      = WB_PC4;
          ctrl.pc_ctrl     = PC_JAL;
          imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: ctrl = '0;
      endcase
    end
  end

  // Unused fields read as x0 so they never look like hazards
  assign rs1 = use_rs1 ? inst[19:15] : '0;
  assign rs2 = use_rs2 ? inst[24:20] : '0;
  assign rd  = ctrl.reg_write ? inst[11:7] : '0;

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      nrst,
  input  reg_addr_t rsel1,
  input  reg_addr_t rsel2,
  output word_t     rdat1,
  output word_t     rdat2,
  input  logic      wen,
  input  reg_addr_t wsel,
  input  word_t     wdat
);

  word_t regs [1:31];
  logic  wr_ok;

  assign wr_ok = wen && (wsel != '0);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wsel] <= wdat;
    end
  end

  // Same-cycle write is visible to decode
  assign rdat1 = (rsel1 == '0) ? '0 :
                 (wr_ok && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 :
                 (wr_ok && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import rv_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      // Lui
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_src_t;

  typedef enum logic [1:0] {
    PC_NONE,
    PC_BEQ,
    PC_BNE,
    PC_JAL
  } pc_ctrl_t;

  // Execute operand source
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  // Decoded control, all zero is a bubble
  typedef struct packed {
    alu_op_t  alu_op;
    logic     alu_src_pc;
    logic     alu_src_imm;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    wb_src_t  wb_src;
    pc_ctrl_t pc_ctrl;
    logic     halt;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic en_f2d;
    logic en_d2e;
    logic en_e2m;
    logic en_m2w;
    logic flush_f2d;
    logic flush_d2e;
    logic flush_e2m;
    logic flush_m2w;
  } stage_ctrl_t;

  // Pipeline registers
  typedef struct packed {
    word_t pc;
    word_t inst;
  } f2d_t;

  typedef struct packed {
    word_t     pc;
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rdat1;
    word_t     rdat2;
  } d2e_t;

  typedef struct packed {
    word_t     pc;
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     alu_out;
    logic      alu_zero;
    word_t     br_target;
    word_t     store_data;
  } e2m_t;

  typedef struct packed {
    word_t     pc;
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     alu_out;
    word_t     dload;
  } m2w_t;

  // addi x0, x0, 0
  localparam word_t NOP_INST  = 32'h0000_0013;
  localparam word_t HALT_INST = 32'hffff_ffff;

endpackage

`default_nettype wire
